/* hw/core_pkg.sv */
// shared constants and types for the video and audio generator
// everything runs from audgen_mclk (12.288 MHz pixel and I2S master clock)
// raster and square coordinates are COORD_W bits and wrap modulo 1024

`default_nettype none

package core_pkg;

    ////////////////////
    // raster timing
    localparam int H_TOTAL   = 400;
    localparam int H_ACTIVE  = 320;
    localparam int H_BPORCH  = 10;
    localparam int V_TOTAL   = 512;
    localparam int V_ACTIVE  = 240;
    localparam int V_BPORCH  = 10;
    // line sync a few clocks after the frame sync
    localparam int HS_COLUMN = 3;
    localparam int COORD_W   = 10;

    ////////////////////
    // test pattern
    localparam int SQUARE_SIZE = 50;
    localparam int SQUARE_X0   = 135;
    localparam int SQUARE_Y0   = 95;
    // grey level, same on r, g and b
    localparam int BG_LEVEL    = 60;

    ////////////////////
    // i2s framing
    localparam int SAMPLE_W    = 16;
    localparam int SLOT_BITS   = 32;
    localparam int SCLK_DIV    = 4;
    localparam int SLOT_CNT_W  = $clog2(SLOT_BITS);
    localparam int SCLK_DIV_W  = $clog2(SCLK_DIV);

    // raster position, column and line
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } raster_pos_t;

    // one pixel, either per channel or as the raw bus word
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_ch_t;

    typedef union packed {
        logic [23:0] raw;
        rgb_ch_t     ch;
    } pixel_u;

    typedef struct packed {
        pixel_u rgb;
        logic   de;
        logic   vs;
        logic   hs;
    } video_out_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } stereo_sample_t;

    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

`default_nettype wire

/* hw/raster_timing.sv */
// free running column and line counters for the 400 x 512 raster
// pos (0, 0) is the frame origin for the whole video path
// counters start at the origin when reset_n releases

`timescale 1ns/100ps
`default_nettype none

module raster_timing
    import core_pkg::*;
(
    input  logic        audgen_mclk,
    input  logic        reset_n,
    output raster_pos_t pos
);

    logic [COORD_W-1:0] x_cnt;
    logic [COORD_W-1:0] y_cnt;
    logic               last_col;
    logic               last_line;

    // end of line and end of frame
    assign last_col  = (x_cnt == COORD_W'(H_TOTAL - 1));
    assign last_line = (y_cnt == COORD_W'(V_TOTAL - 1));

    ////////////////////
    // column counter
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
        end else if (last_col) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    ////////////////////
    // line counter, steps once per line
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            y_cnt <= '0;
        end else if (last_col) begin
            // wrap to line 0 after the last line
            if (last_line) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // position straight from the counters
    assign pos.x = x_cnt;
    assign pos.y = y_cnt;

endmodule

`default_nettype wire

/* hw/test_pattern.sv */
// grey field with a moving black square inside a 320 x 240 window
// all video outputs are registered, one clock behind pos
// square moves by (+1, +1) each frame and wraps modulo 1024

`timescale 1ns/100ps
`default_nettype none

module test_pattern
    import core_pkg::*;
(
    input  logic        audgen_mclk,
    input  logic        reset_n,
    input  raster_pos_t pos,
    output video_out_t  video
);

    logic [COORD_W-1:0] sq_x;
    logic [COORD_W-1:0] sq_y;
    logic [COORD_W-1:0] vis_x;
    logic [COORD_W-1:0] vis_y;
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    logic               frame_origin;
    logic               h_active;
    logic               v_active;
    logic               in_square;
    pixel_u             pix;
    video_out_t         video_next;

    assign frame_origin = (pos.x == '0) && (pos.y == '0);

    ////////////////////
    // region decode
    assign h_active = (pos.x >= COORD_W'(H_BPORCH)) &&
                      (pos.x <  COORD_W'(H_BPORCH + H_ACTIVE));
    assign v_active = (pos.y >= COORD_W'(V_BPORCH)) &&
                      (pos.y <  COORD_W'(V_BPORCH + V_ACTIVE));

    // visible coordinates, offset by the back porch
    assign vis_x = pos.x - COORD_W'(H_BPORCH);
    assign vis_y = pos.y - COORD_W'(V_BPORCH);

    // distance past the square corner, modulo 1024
    assign dx = vis_x - sq_x;
    assign dy = vis_y - sq_y;
    assign in_square = (dx < COORD_W'(SQUARE_SIZE)) && (dy < COORD_W'(SQUARE_SIZE));

    ////////////////////
    // pixel colour
    always_comb begin
        // black outside the window
        pix.raw = '0;
        if (h_active && v_active && !in_square) begin
            pix.ch.r = 8'(BG_LEVEL);
            pix.ch.g = 8'(BG_LEVEL);
            pix.ch.b = 8'(BG_LEVEL);
        end
    end

    always_comb begin
        video_next.rgb = pix;
        video_next.de  = h_active && v_active;
        video_next.vs  = frame_origin;
        video_next.hs  = (pos.x == COORD_W'(HS_COLUMN));
    end

    // square position, steps at the frame origin
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sq_x <= COORD_W'(SQUARE_X0);
            sq_y <= COORD_W'(SQUARE_Y0);
        end else if (frame_origin) begin
            sq_x <= sq_x + 1'b1;
            sq_y <= sq_y + 1'b1;
        end
    end

    // output register, one clock latency
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video <= video_next;
        end
    end

endmodule

`default_nettype wire

/* hw/i2s_serializer.sv */
// i2s master transmitter, sclk = audgen_mclk / 4
// 32 bit slots: 16 data bits MSB first after a one bit delay, then zeros
// stereo sample is taken on the bit step where lrck falls
// first left channel after reset carries zero data

`timescale 1ns/100ps
`default_nettype none

module i2s_serializer
    import core_pkg::*;
(
    input  logic           audgen_mclk,
    input  logic           reset_n,
    input  stereo_sample_t audio_sample,
    output i2s_out_t       audio
);

    logic [SCLK_DIV_W-1:0] div_cnt;
    logic [SLOT_CNT_W-1:0] slot_cnt;
    logic                  bit_step;
    logic                  slot_wrap;
    logic                  lrck;
    logic                  dac;
    logic [SAMPLE_W-1:0]   right_hold;
    logic [SAMPLE_W-1:0]   shift_q;

    ////////////////////
    // bit clock divider
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // divider 3 -> 0, sclk falls here
    assign bit_step  = (div_cnt == SCLK_DIV_W'(SCLK_DIV - 1));
    assign slot_wrap = (slot_cnt == SLOT_CNT_W'(SLOT_BITS - 1));

    ////////////////////
    // slot counter and word select
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt <= '0;
            lrck     <= 1'b0;
        end else if (bit_step) begin
            slot_cnt <= slot_cnt + 1'b1;
            // channel switch at end of slot
            if (slot_wrap) begin
                lrck <= ~lrck;
            end
        end
    end

    ////////////////////
    // data path
    // left goes straight into the shifter on the lrck fall,
    // right half is held until the lrck rise
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            right_hold <= '0;
            shift_q    <= '0;
            dac        <= 1'b0;
        end else if (bit_step) begin
            if (slot_wrap) begin
                // slot 0 of the new channel, one bit delay
                dac <= 1'b0;
                if (lrck) begin
                    // lrck falling, left channel next
                    shift_q    <= audio_sample.left;
                    right_hold <= audio_sample.right;
                end else begin
                    shift_q <= right_hold;
                end
            end else begin
                // slots 1..16 carry data, zeros shift in behind it
                dac     <= shift_q[SAMPLE_W-1];
                shift_q <= {shift_q[SAMPLE_W-2:0], 1'b0};
            end
        end
    end

    assign audio.sclk = div_cnt[SCLK_DIV_W-1];
    assign audio.lrck = lrck;
    assign audio.dac  = dac;

endmodule

`default_nettype wire

/* hw/core_top.sv */
// video test pattern and i2s audio generator
// single clock domain, audgen_mclk is also the pixel clock
// audio_sample is sampled in the audgen_mclk domain

`timescale 1ns/100ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic           audgen_mclk,
    input  logic           reset_n,
    input  stereo_sample_t audio_sample,
    output video_out_t     video,
    output i2s_out_t       audio
);

    // raster position into the pattern generator
    raster_pos_t pos;

    ////////////////////
    // video path
    raster_timing u_raster_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos)
    );

    // syncs, data enable and pixels
    test_pattern u_test_pattern (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .video       (video)
    );

    ////////////////////
    // audio path, independent of the raster
    i2s_serializer u_i2s_serializer (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .audio_sample (audio_sample),
        .audio        (audio)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// 40 ns clock and active low reset for the testbench
// reset_n is held low for 5 rising edges, released just after the 5th

`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic audgen_mclk,
    output logic reset_n
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 5;
    // same small offset as the stimulus
    localparam int RELEASE_DLY_NS = 2;

    initial begin
        audgen_mclk = 1'b0;
        forever #(HALF_PERIOD_NS) audgen_mclk = ~audgen_mclk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge audgen_mclk);
        #(RELEASE_DLY_NS);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* test/core_top_chk.sv */
// protocol assertions on the core_top outputs, bound into the DUT
// all properties are off while reset_n is low

`timescale 1ns/100ps
`default_nettype none

module core_top_chk
    import core_pkg::*;
(
    input logic       audgen_mclk,
    input logic       reset_n,
    input video_out_t video,
    input i2s_out_t   audio
);

    ////////////////////
    // video syncs
    vs_hs_apart: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !(video.vs && video.hs))
        else $error("vs and hs high in the same clock");

    // no active pixels during a sync pulse
    de_off_in_sync: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (video.vs || video.hs) |-> !video.de)
        else $error("de high while a sync is high");

    ////////////////////
    // i2s, word select and data move with the sclk fall only
    lrck_on_sclk_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio.lrck) |-> $fell(audio.sclk))
        else $error("lrck changed away from an sclk fall");

    dac_on_sclk_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio.dac) |-> $fell(audio.sclk))
        else $error("dac changed away from an sclk fall");

endmodule

`default_nettype wire

/* test/tb_top.sv */
// testbench for core_top, stereo samples from a fixed seed LCG
// video and i2s outputs are compared each clock against models kept here
// run is two full frames plus 2000 clocks after reset release

`timescale 1ns/100ps
`default_nettype none

module tb_top
    import core_pkg::*;
();

    localparam int FRAME_CLOCKS   = H_TOTAL * V_TOTAL;
    localparam int RUN_CLOCKS     = 2 * FRAME_CLOCKS + 2000;
    // run length plus reset, about 2 % headroom
    localparam int TIMEOUT_CLOCKS = RUN_CLOCKS + 8400;
    localparam int DRIVE_DLY_NS   = 2;
    localparam int SAMPLE_PERIOD  = 256;
    // between the lrck fall at phase 255 and the next lrck rise at phase 127
    localparam int SAMPLE_PHASE   = 64;
    localparam int COORD_SPAN     = 1 << COORD_W;

    logic           audgen_mclk;
    logic           reset_n;
    stereo_sample_t audio_sample;
    video_out_t     video;
    i2s_out_t       audio;

    logic [31:0]    rng_state;
    int             cycle_cnt;

    // raster model
    int             mx;
    int             my;
    int             origins;
    logic           exp_vs;
    logic           exp_hs;
    logic           exp_de;
    logic [23:0]    exp_rgb;
    logic           line_end;
    logic           frame_end;
    int             hs_line_cnt;
    int             vs_frame_cnt;
    int             de_frame_cnt;

    // i2s model
    logic                exp_sclk;
    logic                m_lrck;
    logic                m_dac;
    int                  m_k;
    logic [SAMPLE_W-1:0] cap_left;
    logic [SAMPLE_W-1:0] cap_right;

    tb_clock u_clock (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    core_top dut (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .audio_sample (audio_sample),
        .video        (video),
        .audio        (audio)
    );

    bind core_top core_top_chk u_core_top_chk (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video       (video),
        .audio       (audio)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // new left and right words from the top half of the LCG
    task automatic draw_sample();
        rng_state = lcg_next(rng_state);
        audio_sample.left = rng_state[31:16];
        rng_state = lcg_next(rng_state);
        audio_sample.right = rng_state[31:16];
    endtask

    task automatic fail_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", test, expected, actual);
        $display("Testbench failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_word(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
            else fail_value(test, expected, actual);
    endtask

    ////////////////////
    // video prediction for the pos seen at this edge
    task automatic predict_video();
        int   vx;
        int   vy;
        int   sx;
        int   sy;
        logic in_win;
        logic in_sq;
        // square steps on the origin edge itself
        if (mx == 0 && my == 0) begin
            origins++;
        end
        vx = mx - H_BPORCH;
        vy = my - V_BPORCH;
        sx = (SQUARE_X0 + origins) % COORD_SPAN;
        sy = (SQUARE_Y0 + origins) % COORD_SPAN;
        in_win = (vx >= 0) && (vx < H_ACTIVE) && (vy >= 0) && (vy < V_ACTIVE);
        // distance past the corner, 10 bit wrap
        in_sq = ((((vx - sx) % COORD_SPAN) + COORD_SPAN) % COORD_SPAN < SQUARE_SIZE) &&
                ((((vy - sy) % COORD_SPAN) + COORD_SPAN) % COORD_SPAN < SQUARE_SIZE);
        exp_vs  = (mx == 0) && (my == 0);
        exp_hs  = (mx == HS_COLUMN);
        exp_de  = in_win;
        exp_rgb = (in_win && !in_sq) ? {3{8'(BG_LEVEL)}} : 24'h0;
        line_end  = (mx == H_TOTAL - 1);
        frame_end = line_end && (my == V_TOTAL - 1);
        // raster advance
        mx++;
        if (mx == H_TOTAL) begin
            mx = 0;
            my++;
            if (my == V_TOTAL) begin
                my = 0;
            end
        end
    endtask

    ////////////////////
    // i2s prediction, n counts edges from reset release
    task automatic predict_i2s(input int n);
        logic [SAMPLE_W-1:0] word;
        exp_sclk = ((n + 1) % SCLK_DIV) >= (SCLK_DIV / 2);
        // bit step where sclk falls
        if (n % SCLK_DIV == SCLK_DIV - 1) begin
            if (m_k == SLOT_BITS - 1) begin
                // lrck falling, take both channels as seen now
                if (m_lrck) begin
                    cap_left  = audio_sample.left;
                    cap_right = audio_sample.right;
                end
                m_lrck = !m_lrck;
                m_k = 0;
            end else begin
                m_k++;
            end
            // slot 0 is the one bit delay
            if (m_k >= 1 && m_k <= SAMPLE_W) begin
                word  = m_lrck ? cap_right : cap_left;
                word  = word >> (SAMPLE_W - m_k);
                m_dac = word[0];
            end else begin
                m_dac = 1'b0;
            end
        end
    endtask

    task automatic check_outputs();
        check_word("vs", 32'(exp_vs), 32'(video.vs));
        check_word("hs", 32'(exp_hs), 32'(video.hs));
        check_word("de", 32'(exp_de), 32'(video.de));
        check_word("rgb", 32'(exp_rgb), 32'(video.rgb.raw));
        check_word("sclk", 32'(exp_sclk), 32'(audio.sclk));
        check_word("lrck", 32'(m_lrck), 32'(audio.lrck));
        check_word("dac", 32'(m_dac), 32'(audio.dac));
    endtask

    // pulse counts per line and per frame
    task automatic tally_counts();
        if (video.hs) begin
            hs_line_cnt++;
        end
        if (video.vs) begin
            vs_frame_cnt++;
        end
        if (video.de) begin
            de_frame_cnt++;
        end
        if (line_end) begin
            check_word("hs_per_line", 32'd1, hs_line_cnt);
            hs_line_cnt = 0;
        end
        if (frame_end) begin
            check_word("vs_per_frame", 32'd1, vs_frame_cnt);
            check_word("de_per_frame", H_ACTIVE * V_ACTIVE, de_frame_cnt);
            vs_frame_cnt = 0;
            de_frame_cnt = 0;
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        rng_state = 32'ha810;
        draw_sample();
        mx = 0;
        my = 0;
        origins = 0;
        hs_line_cnt = 0;
        vs_frame_cnt = 0;
        de_frame_cnt = 0;
        m_lrck = 1'b0;
        m_dac = 1'b0;
        m_k = 0;
        cap_left = '0;
        cap_right = '0;
        // outputs idle during reset
        @(negedge audgen_mclk);
        check_word("reset_video", 32'h0, 32'(video));
        check_word("reset_audio", 32'h0, 32'(audio));
        @(posedge reset_n);
        for (int n = 0; n < RUN_CLOCKS; n++) begin
            @(posedge audgen_mclk);
            predict_video();
            predict_i2s(n);
            #(DRIVE_DLY_NS);
            if (n % SAMPLE_PERIOD == SAMPLE_PHASE) begin
                draw_sample();
            end
            // mid cycle, outputs settled
            @(negedge audgen_mclk);
            check_outputs();
            tally_counts();
        end
        $display("Testbench passed");
        $finish;
    end

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CLOCKS) begin
            @(posedge audgen_mclk);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d clocks", TIMEOUT_CLOCKS);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/core_pkg.sv
hw/raster_timing.sv
hw/test_pattern.sv
hw/i2s_serializer.sv
hw/core_top.sv
test/tb_clock.sv
test/core_top_chk.sv
test/tb_top.sv

/* Makefile */
# Verilator simulation of core_top
# exit status of the sim target is the simulator's own status

SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_top
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
